/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_spi_buf
FILELIST  = project.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* common/spi_buf_params.svh */
`ifndef SPI_BUF_PARAMS_SVH
`define SPI_BUF_PARAMS_SVH

// host word and spi byte widths
`define SPI_WORD_W 32
`define SPI_BYTE_W 8

// words held by each buffer
`define SPI_BUF_DEPTH 10

// clk cycles per sclk half period
`define SPI_HALF_DIV 4

`endif

/* common/spi_buf_pkg.sv */
`include "spi_buf_params.svh"

package spi_buf_pkg;

	// host opcodes, codes 5..7 are unused
	typedef enum logic [2:0] {
		OP_NOP   = 3'd0,
		OP_WRITE = 3'd1,
		OP_START = 3'd2,
		OP_READ  = 3'd3,
		OP_CLEAR = 3'd4
	} cmd_op_e;

	typedef struct packed {
		cmd_op_e                op;
		logic [`SPI_WORD_W-1:0] data; // only used by OP_WRITE
	} host_cmd_t;

	// buffer flags, has_data sits in bit 0
	typedef struct packed {
		logic full;     // write pointer at depth
		logic done;     // everything written was read back
		logic empty;    // write pointer is zero
		logic has_data; // unread words remain
	} buf_status_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_FETCH,  // pull next tx word
		ST_LOAD,   // wait for buffer read data
		ST_SHIFT,
		ST_STORE,  // push assembled rx word
		ST_FINISH
	} shift_state_e;

endpackage

/* hdl/spi_buf_top.sv */
`timescale 1ns/10ps
`include "spi_buf_params.svh"

module spi_buf_top (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     cmd_valid,
	input  spi_buf_pkg::host_cmd_t   cmd,
	input  logic                     miso,
	output logic [`SPI_WORD_W-1:0]   rd_data,
	output logic                     rd_valid,
	output logic                     cmd_error,
	output spi_buf_pkg::buf_status_t tx_status,
	output spi_buf_pkg::buf_status_t rx_status,
	output logic                     sclk,
	output logic                     mosi,
	output logic                     cs_n,
	output logic                     busy,
	output logic                     xfer_done
);

	logic                   tx_wr;
	logic [`SPI_WORD_W-1:0] wr_data;
	logic                   start;
	logic                   rx_rd;
	logic                   clear;
	logic                   tx_rd;
	logic [`SPI_WORD_W-1:0] tx_data;
	logic                   tx_valid;
	logic                   rx_wr;
	logic [`SPI_WORD_W-1:0] rx_data;

	spi_cmd_decode i_cmd_decode (
		.clk       (clk),
		.rst       (rst),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.busy      (busy),
		.tx_status (tx_status),
		.tx_wr     (tx_wr),
		.start     (start),
		.rx_rd     (rx_rd),
		.clear     (clear),
		.cmd_error (cmd_error),
		.wr_data   (wr_data)
	);

	// host fills, engine drains
	spi_word_buffer i_tx_buf (
		.clk      (clk),
		.rst      (rst),
		.clear    (clear),
		.wr       (tx_wr),
		.wr_data  (wr_data),
		.rd       (tx_rd),
		.rd_data  (tx_data),
		.rd_valid (tx_valid),
		.status   (tx_status)
	);

	// engine fills, host drains
	spi_word_buffer i_rx_buf (
		.clk      (clk),
		.rst      (rst),
		.clear    (clear),
		.wr       (rx_wr),
		.wr_data  (rx_data),
		.rd       (rx_rd),
		.rd_data  (rd_data),
		.rd_valid (rd_valid),
		.status   (rx_status)
	);

	spi_shift_engine i_shift_engine (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.tx_status (tx_status),
		.tx_data   (tx_data),
		.tx_valid  (tx_valid),
		.miso      (miso),
		.tx_rd     (tx_rd),
		.rx_wr     (rx_wr),
		.rx_data   (rx_data),
		.sclk      (sclk),
		.mosi      (mosi),
		.cs_n      (cs_n),
		.busy      (busy),
		.xfer_done (xfer_done)
	);

endmodule

/* hdl/spi_cmd_decode.sv */
`timescale 1ns/10ps
`include "spi_buf_params.svh"

module spi_cmd_decode (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     cmd_valid,
	input  spi_buf_pkg::host_cmd_t   cmd,
	input  logic                     busy,
	input  spi_buf_pkg::buf_status_t tx_status,
	output logic                     tx_wr,
	output logic                     start,
	output logic                     rx_rd,
	output logic                     clear,
	output logic                     cmd_error,
	output logic [`SPI_WORD_W-1:0]   wr_data
);

	import spi_buf_pkg::*;

	logic armed; // low until the first edge after reset
	logic valid;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			armed <= 1'b0;
		end else begin
			armed <= 1'b1;
		end
	end

	assign valid   = cmd_valid && armed;
	assign wr_data = cmd.data;

	// exactly one strobe or an error per accepted command
	always_comb begin
		tx_wr     = 1'b0;
		start     = 1'b0;
		rx_rd     = 1'b0;
		clear     = 1'b0;
		cmd_error = 1'b0;
		if (valid) begin
			case (cmd.op)
				OP_NOP: begin
				end
				OP_WRITE: begin
					tx_wr     = !busy;
					cmd_error = busy;
				end
				OP_START: begin
					start     = !busy && tx_status.has_data;
					cmd_error = busy || !tx_status.has_data;
				end
				OP_READ: rx_rd = 1'b1; // fine during a transfer
				OP_CLEAR: begin
					clear     = !busy;
					cmd_error = busy;
				end
				default: cmd_error = 1'b1;
			endcase
		end
	end

endmodule

/* hdl/spi_shift_engine.sv */
`timescale 1ns/10ps
`include "spi_buf_params.svh"

module spi_shift_engine (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     start,
	input  spi_buf_pkg::buf_status_t tx_status,
	input  logic [`SPI_WORD_W-1:0]   tx_data,
	input  logic                     tx_valid,
	input  logic                     miso,
	output logic                     tx_rd,
	output logic                     rx_wr,
	output logic [`SPI_WORD_W-1:0]   rx_data,
	output logic                     sclk,
	output logic                     mosi,
	output logic                     cs_n,
	output logic                     busy,
	output logic                     xfer_done
);

	import spi_buf_pkg::*;

	localparam int BYTES  = `SPI_WORD_W / `SPI_BYTE_W;
	localparam int DIV_W  = $clog2(`SPI_HALF_DIV + 1);
	localparam int BIT_W  = $clog2(`SPI_BYTE_W);
	localparam int BCNT_W = $clog2(BYTES);

	shift_state_e           state;
	logic [DIV_W-1:0]       div_cnt;
	logic [BIT_W-1:0]       bit_cnt;  // bit within the current byte
	logic [BCNT_W-1:0]      byte_cnt;
	logic [`SPI_WORD_W-1:0] shreg;    // tx out the top, rx in at the bottom
	logic                   miso_q;
	logic                   half_tick;
	logic                   byte_end;
	logic                   last_bit;

	assign half_tick = (div_cnt == DIV_W'(`SPI_HALF_DIV - 1));
	assign byte_end  = (bit_cnt == BIT_W'(`SPI_BYTE_W - 1));
	assign last_bit  = byte_end && (byte_cnt == BCNT_W'(BYTES - 1));

	assign busy      = (state != ST_IDLE);
	assign xfer_done = (state == ST_FINISH);
	assign tx_rd     = (state == ST_FETCH) && tx_status.has_data;
	assign rx_wr     = (state == ST_STORE);
	assign rx_data   = shreg;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= ST_IDLE;
			div_cnt  <= '0;
			bit_cnt  <= '0;
			byte_cnt <= '0;
			sclk     <= 1'b0;
			mosi     <= 1'b0;
			cs_n     <= 1'b1;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start) begin
						state <= ST_FETCH;
						cs_n  <= 1'b0; // select drops together with busy
					end
				end
				ST_FETCH: state <= tx_status.has_data ? ST_LOAD : ST_FINISH;
				ST_LOAD: begin
					if (tx_valid) begin
						state    <= ST_SHIFT;
						div_cnt  <= '0;
						bit_cnt  <= '0;
						byte_cnt <= '0;
						mosi     <= tx_data[`SPI_WORD_W-1]; // first bit ahead of rising edge
					end
				end
				ST_SHIFT: begin
					if (half_tick) begin
						div_cnt <= '0;
						sclk    <= ~sclk;
						if (sclk) begin
							// falling edge, present the next bit
							mosi    <= last_bit ? 1'b0 : shreg[`SPI_WORD_W-2];
							bit_cnt <= byte_end ? '0 : bit_cnt + 1'b1;
							if (byte_end) begin
								byte_cnt <= byte_cnt + 1'b1;
							end
							if (last_bit) begin
								state <= ST_STORE;
							end
						end
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end
				ST_STORE: state <= ST_FETCH;
				ST_FINISH: begin
					state <= ST_IDLE;
					cs_n  <= 1'b1;
					mosi  <= 1'b0;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// datapath: sample on rising sclk, shift on falling sclk
	always_ff @(posedge clk) begin
		if (state == ST_LOAD && tx_valid) begin
			shreg <= tx_data;
		end else if (state == ST_SHIFT && half_tick) begin
			if (!sclk) begin
				miso_q <= miso;
			end else begin
				shreg <= {shreg[`SPI_WORD_W-2:0], miso_q};
			end
		end
	end

endmodule

/* project.f */
+incdir+common
common/spi_buf_pkg.sv
spi_buffer/spi_word_buffer.sv
hdl/spi_cmd_decode.sv
hdl/spi_shift_engine.sv
hdl/spi_buf_top.sv
test/spi_buf_assertions.sv
test/tb_spi_buf.sv

/* spi_buffer/spi_word_buffer.sv */
`timescale 1ns/10ps
`include "spi_buf_params.svh"

module spi_word_buffer (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     clear,
	input  logic                     wr,
	input  logic [`SPI_WORD_W-1:0]   wr_data,
	input  logic                     rd,
	output logic [`SPI_WORD_W-1:0]   rd_data,
	output logic                     rd_valid,
	output spi_buf_pkg::buf_status_t status
);

	// one extra pointer value so full can be seen at depth
	localparam int PTR_W = $clog2(`SPI_BUF_DEPTH + 1);
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`SPI_BUF_DEPTH);

	logic [`SPI_WORD_W-1:0] mem [`SPI_BUF_DEPTH];
	logic [PTR_W-1:0]       wr_ptr;
	logic [PTR_W-1:0]       rd_ptr;
	logic                   done_q;
	logic                   full;
	logic                   has_data;
	logic                   wr_ok;
	logic                   rd_ok;
	logic                   drained;

	assign full     = (wr_ptr == PTR_LAST);
	assign has_data = (wr_ptr != rd_ptr);

	assign wr_ok = wr && !full;     // writes past depth are dropped
	assign rd_ok = rd && has_data;

	// all words consumed and the bus is quiet, so rewind
	assign drained = (wr_ptr == rd_ptr) && (wr_ptr != '0) && !wr && !rd;

	always_comb begin
		status.full     = full;
		status.done     = done_q;
		status.empty    = (wr_ptr == '0);
		status.has_data = has_data;
	end

	always_ff @(posedge clk) begin
		if (wr_ok && !clear) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// pointers and the done flag
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			done_q <= 1'b0;
		end else if (clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			done_q <= 1'b0;
		end else if (drained) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			done_q <= 1'b1;
		end else begin
			if (wr_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
				done_q <= 1'b0; // fresh data pending again
			end
			if (rd_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// read port, one cycle latency, zero on a refused read
	always_ff @(posedge clk) begin
		if (rd_ok) begin
			rd_data <= mem[rd_ptr];
		end else begin
			rd_data <= '0;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd_ok;
		end
	end

endmodule

/* test/spi_buf_assertions.sv */
`timescale 1ns/10ps

module spi_buf_assertions (
	input logic                     clk,
	input logic                     rst,
	input logic                     cmd_valid,
	input spi_buf_pkg::host_cmd_t   cmd,
	input logic                     cmd_error,
	input spi_buf_pkg::buf_status_t rx_status,
	input logic                     rd_valid,
	input logic                     cs_n,
	input logic                     busy,
	input logic                     xfer_done
);

	import spi_buf_pkg::*;

	cs_held: assert property (@(posedge clk) disable iff (rst) busy |-> !cs_n)
		else $error("cs_n high during a transfer");

	done_pulse: assert property (@(posedge clk) disable iff (rst) xfer_done |=> !xfer_done)
		else $error("xfer_done longer than one cycle");

	// refused command must not kick off a transfer
	refused_idle: assert property (@(posedge clk) disable iff (rst)
		(cmd_valid && cmd_error && !busy) |=> !busy)
		else $error("refused command changed busy");

	read_latency: assert property (@(posedge clk) disable iff (rst)
		(cmd_valid && cmd.op == OP_READ && rx_status.has_data) |=> rd_valid)
		else $error("rd_valid missing one cycle after READ");

endmodule

bind spi_buf_top spi_buf_assertions i_assertions (
	.clk       (clk),
	.rst       (rst),
	.cmd_valid (cmd_valid),
	.cmd       (cmd),
	.cmd_error (cmd_error),
	.rx_status (rx_status),
	.rd_valid  (rd_valid),
	.cs_n      (cs_n),
	.busy      (busy),
	.xfer_done (xfer_done)
);

/* test/spi_buf_cases.txt */
// columns: op data mode expect, all hex; 1-7 host opcodes (expect cmd_error, READ expect rd_data)
// 8 fill n words, 9 wait xfer_done, a read back n words (mode 1 inverted), b {busy,cs_n,rx,tx}, f end
b 00000000 0 122 // after reset
2 00000000 0 1   // start with empty tx
7 00000000 0 1   // unknown opcode
b 00000000 0 122
1 a5c3f00d 0 0
1 a5c3f00e 0 0
2 00000000 0 0
9 00000000 0 0
a a5c3f00d 0 2
b 00000000 0 166 // both buffers done
3 00000000 0 0   // read with nothing left
8 12345678 0 3
2 00000000 1 0
1 deadbeef 0 1   // write while busy
4 00000000 0 1   // clear while busy
9 00000000 0 0
a 12345678 1 3
8 00c0ffee 0 b   // one past depth
b 00000000 0 169
2 00000000 0 0
9 00000000 0 0
a 00c0ffee 0 a
8 0badf00d 0 2
4 00000000 0 0
b 00000000 0 122
2 00000000 0 1
f 00000000 0 0

/* test/tb_spi_buf.sv */
`timescale 1ns/10ps
`include "spi_buf_params.svh"

module tb_spi_buf;

	import spi_buf_pkg::*;

	localparam int MAX_LINES    = 64;
	localparam int XFER_TIMEOUT = 20000; // clk cycles allowed per transfer

	// case file actions beyond the host opcodes
	localparam logic [31:0] ACT_FILL   = 32'h8;
	localparam logic [31:0] ACT_WAIT   = 32'h9;
	localparam logic [31:0] ACT_DRAIN  = 32'ha;
	localparam logic [31:0] ACT_STATUS = 32'hb;
	localparam logic [31:0] ACT_END    = 32'hf;

	logic                   clk;
	logic                   rst;
	logic                   cmd_valid;
	host_cmd_t              cmd;
	logic                   miso;
	logic [`SPI_WORD_W-1:0] rd_data;
	logic                   rd_valid;
	logic                   cmd_error;
	buf_status_t            tx_status;
	buf_status_t            rx_status;
	logic                   sclk;
	logic                   mosi;
	logic                   cs_n;
	logic                   busy;
	logic                   xfer_done;

	logic [31:0] cases [4*MAX_LINES];
	logic        invert;     // slave answers with ~mosi
	logic [31:0] mosi_shift;
	int          mosi_bits;
	logic [31:0] mosi_words [$];
	int          errors;

	spi_buf_top i_spi_buf_top (
		.clk       (clk),
		.rst       (rst),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.miso      (miso),
		.rd_data   (rd_data),
		.rd_valid  (rd_valid),
		.cmd_error (cmd_error),
		.tx_status (tx_status),
		.rx_status (rx_status),
		.sclk      (sclk),
		.mosi      (mosi),
		.cs_n      (cs_n),
		.busy      (busy),
		.xfer_done (xfer_done)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// slave model collecting what the master shifts out
	always @(posedge sclk) begin
		if (!cs_n) begin
			mosi_shift = {mosi_shift[30:0], mosi};
			mosi_bits++;
			if (mosi_bits == `SPI_WORD_W) begin
				mosi_words.push_back(mosi_shift);
				mosi_bits = 0;
			end
		end
	end

	always @(posedge clk) begin
		#1 miso = invert ? ~mosi : mosi;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	// idle gap then one command cycle that ends where read data is stable
	task automatic send_cmd(input logic [2:0] op, input logic [31:0] data,
			input logic exp_error);
		repeat ($urandom_range(3)) @(posedge clk);
		@(posedge clk);
		#1;
		cmd_valid = 1'b1;
		cmd.op    = cmd_op_e'(op);
		cmd.data  = data;
		@(negedge clk);
		check_value("cmd_error", 32'(exp_error), 32'(cmd_error));
		@(posedge clk);
		#1;
		cmd_valid = 1'b0;
		@(negedge clk);
	endtask

	task automatic read_word(input logic [31:0] expected, input logic exp_valid);
		send_cmd(OP_READ, '0, 1'b0);
		check_value("rd_valid", 32'(exp_valid), 32'(rd_valid));
		check_value("rd_data", expected, rd_data);
	endtask

	task automatic fill_words(input logic [31:0] first, input int count);
		int i;
		for (i = 0; i < count; i++) begin
			send_cmd(OP_WRITE, first + 32'(i), 1'b0);
		end
	endtask

	// read back count words and match them against the mosi capture
	task automatic drain_words(input logic [31:0] first, input logic inv, input int count);
		int          i;
		logic [31:0] word;
		for (i = 0; i < count; i++) begin
			word = first + 32'(i);
			read_word(inv ? ~word : word, 1'b1);
			if (mosi_words.size() == 0) begin
				$display("ERROR: word %h was never seen on mosi", word);
				errors++;
			end else begin
				check_value("mosi word", word, mosi_words.pop_front());
			end
		end
	endtask

	task automatic wait_xfer_done();
		int cycles;
		cycles = 0;
		while (!xfer_done && cycles < XFER_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!xfer_done) begin
			$display("ERROR: xfer_done did not arrive within %0d cycles", XFER_TIMEOUT);
			errors++;
		end
	endtask

	task automatic check_status(input logic [31:0] expected);
		@(posedge clk);
		@(negedge clk);
		check_value("{busy, cs_n, rx_status, tx_status}", expected,
			32'({busy, cs_n, rx_status, tx_status}));
		if (!expected[9]) begin
			// mode 0 idles with sclk and mosi low
			check_value("sclk", '0, 32'(sclk));
			check_value("mosi", '0, 32'(mosi));
		end
	endtask

	initial begin
		int          line;
		logic [31:0] op;
		logic [31:0] data;
		logic [31:0] mode;
		logic [31:0] expv;
		void'($urandom(62));
		rst        = 1'b1;
		cmd_valid  = 1'b0;
		cmd        = '0;
		miso       = 1'b0;
		invert     = 1'b0;
		mosi_shift = '0;
		mosi_bits  = 0;
		errors     = 0;
		$readmemh("test/spi_buf_cases.txt", cases);
		repeat (5) @(posedge clk);
		#1;
		rst  = 1'b0;
		line = 0;
		while (line < MAX_LINES && cases[4*line] !== ACT_END) begin
			op   = cases[4*line];
			data = cases[4*line+1];
			mode = cases[4*line+2];
			expv = cases[4*line+3];
			case (op)
				ACT_FILL:   fill_words(data, int'(expv));
				ACT_WAIT:   wait_xfer_done();
				ACT_DRAIN:  drain_words(data, mode[0], int'(expv));
				ACT_STATUS: check_status(expv);
				32'(OP_READ): read_word(expv, expv != 0); // zero means no data
				default: begin
					if (op == 32'(OP_START)) begin
						invert = mode[0];
					end
					send_cmd(op[2:0], data, expv[0]);
				end
			endcase
			line++;
		end
		if (mosi_words.size() != 0 || mosi_bits != 0) begin
			$display("ERROR: mosi carried %0d extra words and %0d extra bits",
				mosi_words.size(), mosi_bits);
			errors++;
		end
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
